// File: tb.f
logic/cpu_pkg.sv
logic/pipe_reg.sv
logic/ex_alu.sv
logic/branch_resolve.sv
logic/ex_stage.sv
verif/ex_stage_assert.sv
verif/ex_stage_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ex_stage_tb
RTL_TOP   = ex_stage
FILELIST  = tb.f
OBJ_DIR   = obj_dir
RTL_FILES = $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/ex_stage_tb.sv
// simulation top for the execute stage that runs lfsr driven issues against a cycle model.

module ex_stage_tb
    import cpu_pkg::*;
    ();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int DRIVE_DLY      = 2;
    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    logic              clk;
    logic              reset;
    issue_t            issue_i;
    mem_t              mem_o;
    logic              redirect_o;
    logic [DATA_W-1:0] redirect_pc_o;

    logic [31:0]         lfsr_state;
    logic [DATA_W-1:0]   pc_cnt;
    logic [ALU_OP_W-1:0] op_table [0:15];
    issue_t              cur_issue;
    issue_t              m_ex;       // model of the issue register.
    mem_t                m_mem;      // model of the mem register.
    logic                redir_d1;
    logic                redir_d2;
    int                  err_count   = 0;
    int                  check_count = 0;
    int                  redir_count = 0;
    int                  cycle_cnt   = 0;

    ex_stage dut
    (
        .clk           (clk),
        .reset         (reset),
        .issue_i       (issue_i),
        .mem_o         (mem_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [DATA_W-1:0] model_next_pc(input issue_t b);
        if (b.jump || (b.branch && b.r_data_p1 == b.r_data_p2))
        begin
            return b.brn_eq_pc;
        end
        return b.curr_pc + PC_STEP;
    endfunction

    function automatic logic model_mispredict(input issue_t b);
        return b.valid && (model_next_pc(b) != b.next_pred_pc);
    endfunction

    function automatic logic [DATA_W-1:0] model_result(input issue_t b);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] bb;
        logic [DATA_W-1:0] r;
        logic [4:0]        sh;
        a  = b.r_data_p1;
        sh = b.shamt[4:0];
        if (b.alu_src == SRC_SIMM)
            bb = b.sign_imm;
        else if (b.alu_src == SRC_ZIMM)
            bb = {16'h0000, b.sign_imm[15:0]};
        else
            bb = b.r_data_p2;
        case (b.alu_op)
            ALU_ADD:  r = a + bb;
            ALU_SUB:  r = a - bb;
            ALU_AND:  r = a & bb;
            ALU_OR:   r = a | bb;
            ALU_XOR:  r = a ^ bb;
            ALU_NOR:  r = ~(a | bb);
            ALU_SLT:  r = ($signed(a) < $signed(bb)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < bb) ? 32'd1 : 32'd0;
            ALU_SLL:  r = b.r_data_p2 << sh;
            ALU_SRL:  r = b.r_data_p2 >> sh;
            ALU_SRA:
            begin
                r = b.r_data_p2 >> sh;
                if (b.r_data_p2[31])
                    r = r | ~(32'hffff_ffff >> sh);  // fill with sign.
            end
            ALU_LUI:  r = {bb[15:0], 16'h0000};
            default:  r = '0;
        endcase
        if (b.valid && (b.jump || b.branch))
            r = b.curr_pc + PC_STEP;  // link value.
        return r;
    endfunction

    function automatic mem_t model_mem(input issue_t b);
        mem_t m;
        m.valid      = b.valid;
        m.reg_wr     = b.reg_wr;
        m.mem_to_reg = b.mem_to_reg;
        m.mem_wr     = b.mem_wr;
        m.wr_reg     = b.reg_dst ? b.rd : b.rt;
        m.alu_result = model_result(b);
        m.store_data = b.r_data_p2;
        m.pc         = b.curr_pc;
        return m;
    endfunction

    task automatic make_issue(output issue_t b);
        logic [31:0] r;
        b = '0;
        take_bits(3, r);
        b.valid = (r[2:0] != 3'd0);  // one in eight invalid.
        take_bits(6, r);
        b.op = r[5:0];
        take_bits(2, r);
        if (r[1:0] == 2'd0)
        begin
            take_bits(1, r);
            b.jump   = r[0];
            b.branch = ~r[0];
        end
        take_bits(3, r);
        b.reg_wr     = r[0];
        b.mem_to_reg = r[1];
        b.mem_wr     = r[2];
        take_bits(4, r);
        b.alu_op = op_table[r[3:0]];
        take_bits(3, r);
        b.alu_src = r[2:0];
        take_bits(1, r);
        b.reg_dst = r[0];
        take_bits(15, r);
        b.rt = r[4:0];
        b.rs = r[9:5];
        b.rd = r[14:10];
        take_bits(32, r);
        b.r_data_p1 = r;
        take_bits(32, r);
        b.r_data_p2 = r;
        take_bits(1, r);
        if (b.branch && r[0])
            b.r_data_p2 = b.r_data_p1;  // taken branch.
        take_bits(32, r);
        b.brn_eq_pc = {r[31:2], 2'b00};
        take_bits(16, r);
        b.sign_imm = {{16{r[15]}}, r[15:0]};
        take_bits(6, r);
        b.shamt   = r[5:0];
        b.curr_pc = pc_cnt;
        take_bits(1, r);
        b.next_pred_pc = pc_cnt + PC_STEP;
        if (b.jump || b.branch)
        begin
            b.brn_pred = r[0];
            if (r[0])
                b.next_pred_pc = b.brn_eq_pc;
        end
        pc_cnt = pc_cnt + PC_STEP;
    endtask

    task automatic note_error(input string msg);
        err_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic update_model();
        mem_t next_mem;
        next_mem = model_mem(m_ex);
        if (model_mispredict(m_ex))
            m_ex = '0;  // wrong path issue dropped.
        else
            m_ex = cur_issue;
        m_mem = next_mem;
    endtask

    task automatic check_outputs();
        logic exp_redir;
        exp_redir = model_mispredict(m_ex);
        check_count++;
        if (mem_o !== m_mem)
            note_error($sformatf("mem_o valid %b/%b result %h/%h wr_reg %0d/%0d (got/exp)",
                mem_o.valid, m_mem.valid, mem_o.alu_result, m_mem.alu_result,
                mem_o.wr_reg, m_mem.wr_reg));
        if (redirect_o !== exp_redir)
            note_error($sformatf("redirect_o %b, expected %b", redirect_o, exp_redir));
        if (redirect_pc_o !== model_next_pc(m_ex))
            note_error($sformatf("redirect_pc_o %h, expected %h",
                redirect_pc_o, model_next_pc(m_ex)));
        if (!m_ex.valid && redirect_o === 1'b1)
            note_error("redirect raised by an invalid instruction");
        if (redir_d1 && mem_o.valid !== 1'b1)
            note_error("mispredicting instruction missing on mem_o");
        if (redir_d2 && mem_o !== '0)
            note_error("dropped issue reached mem_o");
        if (redirect_o === 1'b1)
            redir_count++;
        redir_d2 = redir_d1;
        redir_d1 = (redirect_o === 1'b1);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        op_table = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                     ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
                     6'h01, 6'h10, 6'h21, 6'h3f};  // last four unlisted.
        lfsr_state = 32'h1416_8fc1;
        pc_cnt     = 32'h0040_0000;
        make_issue(cur_issue);
        cur_issue.valid = 1'b1;  // live issue held across reset.
        issue_i    = cur_issue;
        m_ex       = '0;
        m_mem      = '0;
        redir_d1   = 1'b0;
        redir_d2   = 1'b0;
        reset      = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(negedge clk);
        if (mem_o !== '0 || redirect_o !== 1'b0)
            note_error("outputs not idle after reset");
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
        begin
            @(posedge clk);
            update_model();
            #DRIVE_DLY;
            if (cyc < NUM_CYCLES - 2)
                make_issue(cur_issue);
            else
                cur_issue = '0;  // drain.
            issue_i = cur_issue;
            @(negedge clk);
            check_outputs();
        end
        $display("checks %0d, redirects %0d, errors %0d", check_count, redir_count, err_count);
        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verif/ex_stage_assert.sv
// concurrent checks on redirect and valid behavior, bound into the execute stage.

module ex_stage_assert
    import cpu_pkg::*;
    (
        input logic   clk,
        input logic   reset,
        input logic   redirect_o,
        input issue_t ex_q,
        input mem_t   mem_o
    );

    // the wrong path bubble cannot mispredict again.
    assert property (@(posedge clk) disable iff (reset) redirect_o |=> !redirect_o)
        else $error("redirect_o high in two consecutive cycles");

    assert property (@(posedge clk) disable iff (reset) redirect_o |=> (ex_q == '0))
        else $error("execute register not cleared after a redirect");

    assert property (@(posedge clk) reset |-> !mem_o.valid)
        else $error("mem_o.valid high during reset");

endmodule

bind ex_stage ex_stage_assert u_assert
(
    .clk        (clk),
    .reset      (reset),
    .redirect_o (redirect_o),
    .ex_q       (ex_q),
    .mem_o      (mem_o)
);

// File: logic/ex_stage.sv
// execute stage top: issue register, alu, branch resolve and the register to memory.

module ex_stage
    import cpu_pkg::*;
    (
        input  logic                clk,
        input  logic                reset,
        input  issue_t              issue_i,
        output mem_t                mem_o,
        output logic                redirect_o,
        output logic [DATA_W-1:0]   redirect_pc_o
    );

    issue_t            ex_q;
    mem_t              ex_res;
    logic [DATA_W-1:0] alu_result;
    logic              mispredict;

    // a mispredict drops the wrong path issue arriving this cycle.
    pipe_reg #(.payload_t(issue_t)) u_ex_reg
    (
        .clk   (clk),
        .reset (reset),
        .clr_i (mispredict),
        .d_i   (issue_i),
        .q_o   (ex_q)
    );

    ex_alu u_alu
    (
        .ex_i     (ex_q),
        .result_o (alu_result)
    );

    branch_resolve u_brn
    (
        .ex_i          (ex_q),
        .mispredict_o  (mispredict),
        .redirect_pc_o (redirect_pc_o)
    );

    assign redirect_o = mispredict;

    assign ex_res.valid      = ex_q.valid;
    assign ex_res.reg_wr     = ex_q.reg_wr;
    assign ex_res.mem_to_reg = ex_q.mem_to_reg;
    assign ex_res.mem_wr     = ex_q.mem_wr;
    assign ex_res.wr_reg     = ex_q.reg_dst ? ex_q.rd : ex_q.rt;
    assign ex_res.alu_result = alu_result;
    assign ex_res.store_data = ex_q.r_data_p2;
    assign ex_res.pc         = ex_q.curr_pc;

    // mispredicting instruction itself still moves on.
    pipe_reg #(.payload_t(mem_t)) u_mem_reg
    (
        .clk   (clk),
        .reset (reset),
        .clr_i (1'b0),
        .d_i   (ex_res),
        .q_o   (mem_o)
    );

endmodule

// File: logic/branch_resolve.sv
// resolves jumps and branches against the fetch prediction and flags a mispredict.

module branch_resolve
    import cpu_pkg::*;
    (
        input  issue_t              ex_i,
        output logic                mispredict_o,
        output logic [DATA_W-1:0]   redirect_pc_o
    );

    logic [DATA_W-1:0] seq_pc;
    logic [DATA_W-1:0] actual_pc;
    logic              operands_eq;
    logic              take_target;

    assign seq_pc      = ex_i.curr_pc + PC_STEP;
    assign operands_eq = (ex_i.r_data_p1 == ex_i.r_data_p2);

    // beq style compare only.
    assign take_target = ex_i.jump | (ex_i.branch & operands_eq);

    always_comb
    begin
        if (take_target)
        begin
            actual_pc = ex_i.brn_eq_pc;
        end
        else
        begin
            actual_pc = seq_pc;  // fall through.
        end
    end

    // any disagreement with fetch counts, not just branch direction.
    assign mispredict_o  = ex_i.valid & (actual_pc != ex_i.next_pred_pc);
    assign redirect_pc_o = actual_pc;

endmodule

// File: logic/ex_alu.sv
// execute alu: picks the second operand and computes the result or the link value.

module ex_alu
    import cpu_pkg::*;
    (
        input  issue_t              ex_i,
        output logic [DATA_W-1:0]   result_o
    );

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;
    logic [4:0]        shift_amt;
    logic              is_link;

    assign op_a      = ex_i.r_data_p1;
    assign shift_amt = ex_i.shamt[4:0];  // 32 bit shifter.

    // jumps and branches write back the return address.
    assign is_link = ex_i.valid & (ex_i.jump | ex_i.branch);

    // second operand mux.
    always_comb
    begin
        case (ex_i.alu_src)
            SRC_SIMM:
            begin
                op_b = ex_i.sign_imm;
            end
            SRC_ZIMM:
            begin
                op_b = {16'h0000, ex_i.sign_imm[15:0]};
            end
            default:
            begin
                op_b = ex_i.r_data_p2;  // SRC_REG and unused codes.
            end
        endcase
    end

    always_comb
    begin
        case (ex_i.alu_op)
            ALU_ADD:
                alu_res = op_a + op_b;
            ALU_SUB:
                alu_res = op_a - op_b;
            ALU_AND:
                alu_res = op_a & op_b;
            ALU_OR:
                alu_res = op_a | op_b;
            ALU_XOR:
                alu_res = op_a ^ op_b;
            ALU_NOR:
                alu_res = ~(op_a | op_b);
            ALU_SLT:
                alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:
                alu_res = {31'd0, op_a < op_b};
            // fixed shifts act on rt.
            ALU_SLL:
                alu_res = ex_i.r_data_p2 << shift_amt;
            ALU_SRL:
                alu_res = ex_i.r_data_p2 >> shift_amt;
            ALU_SRA:
                alu_res = $unsigned($signed(ex_i.r_data_p2) >>> shift_amt);
            ALU_LUI:
                alu_res = {op_b[15:0], 16'h0000};
            default:
                alu_res = '0;  // unknown op.
        endcase
    end

    assign result_o = is_link ? (ex_i.curr_pc + PC_STEP) : alu_res;

endmodule

// File: logic/pipe_reg.sv
// clearable pipeline register for any packed payload, used at each stage boundary.

module pipe_reg
    #(
        parameter type payload_t = logic [31:0]
    )
    (
        input  logic     clk,
        input  logic     reset,
        input  logic     clr_i,
        input  payload_t d_i,
        output payload_t q_o
    );

    // clear wins over load, so a dropped bundle never lands.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            q_o <= '0;
        end
        else if (clr_i)
        begin
            q_o <= '0;  // bubble.
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

// File: logic/cpu_pkg.sv
// bundle types and encodings shared by the execute stage and its testbench.

package cpu_pkg;

    // widths.
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 6;
    localparam int ALU_OP_W   = 6;
    localparam int SRC_W      = 3;
    localparam int SHAMT_W    = 6;

    // alu operation codes, mips funct style.
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 6'h20;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 6'h22;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 6'h24;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 6'h25;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 6'h26;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 6'h27;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 6'h2a;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 6'h2b;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 6'h00;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 6'h02;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 6'h03;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 6'h0f;

    // second operand source.
    localparam logic [SRC_W-1:0] SRC_REG  = 3'd0;  // r_data_p2.
    localparam logic [SRC_W-1:0] SRC_SIMM = 3'd1;  // sign extended immediate.
    localparam logic [SRC_W-1:0] SRC_ZIMM = 3'd2;  // low half, zero extended.

    // sequential pc increment.
    localparam logic [DATA_W-1:0] PC_STEP = 32'd4;

    // issue bundle, decode to execute.
    typedef struct packed {
        logic                  valid;
        logic [OPC_W-1:0]      op;
        logic                  jump;
        logic                  branch;
        logic                  reg_wr;
        logic                  mem_to_reg;
        logic                  mem_wr;
        logic [ALU_OP_W-1:0]   alu_op;
        logic [SRC_W-1:0]      alu_src;
        logic                  reg_dst;       // 1 selects rd as destination.
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     r_data_p1;
        logic [DATA_W-1:0]     r_data_p2;
        logic [DATA_W-1:0]     brn_eq_pc;     // branch or jump target.
        logic [DATA_W-1:0]     sign_imm;
        logic [SHAMT_W-1:0]    shamt;
        logic                  brn_pred;
        logic [DATA_W-1:0]     curr_pc;
        logic [DATA_W-1:0]     next_pred_pc;  // pc that fetch went on with.
    } issue_t;

    // reduced bundle, execute to memory.
    typedef struct packed {
        logic                  valid;
        logic                  reg_wr;
        logic                  mem_to_reg;
        logic                  mem_wr;
        logic [REG_ADDR_W-1:0] wr_reg;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     store_data;
        logic [DATA_W-1:0]     pc;
    } mem_t;

endpackage
